// File: vlog.f
source/gpio_bridge_pkg.sv
source/ahb_slave_port.sv
source/toggle_sync.sv
source/apb_master_port.sv
source/apb_gpio.sv
source/gpio_subsystem_top.sv
bench/gpio_subsystem_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the gpio subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module gpio_subsystem_tb -f vlog.f --Mdir obj_dir -o gpio_sim

./obj_dir/gpio_sim | tee sim.log

if grep -qx "Simulation passed" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi

// File: bench/gpio_subsystem_tb.sv
module gpio_subsystem_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_BANKS     = 2;
  localparam int N_RANDOM    = 300;
  localparam int N_DIRECTED  = 10 * N_BANKS + 3;   // transfers before the random mix
  localparam int RST_CYCLES  = 10;
  localparam int PIN_SETTLE  = 12;                 // pclk cycles after a gpio_in change
  localparam int WATCHDOG_NS = ((N_RANDOM + N_DIRECTED) * 60 + RST_CYCLES) * 20;
  localparam logic [31:0] SEED = 32'hcaa2daeb;

  logic                 HCLK;
  logic                 HRESETn;
  logic                 PCLK;
  logic                 PRESETn;
  logic                 HSEL;
  logic [31:0]          HADDR;
  logic                 HWRITE;
  logic [2:0]           HSIZE;
  logic [3:0]           HPROT;
  logic [1:0]           HTRANS;
  logic [31:0]          HWDATA;
  logic                 HREADY;
  logic [31:0]          HRDATA;
  logic                 HREADYOUT;
  logic                 HRESP;
  logic [N_BANKS*8-1:0] gpio_in;
  logic [N_BANKS*8-1:0] gpio_out;
  logic [N_BANKS*8-1:0] gpio_oe;

  // register model
  logic [7:0]           m_out [N_BANKS];
  logic [7:0]           m_dir [N_BANKS];
  logic [N_BANKS*8-1:0] pins_in;        // value held on gpio_in
  int                   n_checks = 0;
  int                   n_errors = 0;

  gpio_subsystem_top #(.SYNC_DEPTH(3), .N_BANKS(N_BANKS), .PADDR_SIZE(8)) dut (.*);

  initial begin
    HCLK = 1'b0;
    forever #10 HCLK = ~HCLK;
  end

  initial begin
    PCLK = 1'b0;
    forever #15 PCLK = ~PCLK;   // unrelated to hclk
  end

  ////////////////////////////////////////////////////////////////////////////
  // checking and model helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    n_checks++;
    assert (got === exp) else begin
      n_errors++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // byte the gpio slave should return at an apb address
  function automatic logic [7:0] model_byte(input logic [7:0] a);
    logic [7:0] res;
    int         b;
    res = 8'h00;
    b   = int'(a[7:2]);
    if (b < N_BANKS) begin
      case (a[1:0])
        2'd0: res = m_out[b];
        2'd1: res = m_dir[b];
        2'd2: res = pins_in[b*8 +: 8];   // synchronized pins
        default: res = 8'h00;            // reserved
      endcase
    end
    return res;
  endfunction

  task automatic verify_pins();
    logic [N_BANKS*8-1:0] exp_out;
    logic [N_BANKS*8-1:0] exp_oe;
    for (int b = 0; b < N_BANKS; b++) begin
      exp_oe[b*8 +: 8]  = m_dir[b];
      exp_out[b*8 +: 8] = m_out[b] & m_dir[b];   // only driven bits show
    end
    compare("gpio_oe", 64'(gpio_oe), 64'(exp_oe));
    compare("gpio_out", 64'(gpio_out), 64'(exp_out));
  endtask

  task automatic drive_new_pins();
    logic [63:0] rnd;
    rnd = {$urandom(), $urandom()};
    @(posedge HCLK);
    pins_in = rnd[N_BANKS*8-1:0];
    gpio_in <= pins_in;
    repeat (PIN_SETTLE) @(posedge PCLK);   // let the pin synchronizer settle
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one ahb transfer, checked against the model
  ////////////////////////////////////////////////////////////////////////////

  task automatic bus_transfer(input logic [31:0] addr, input logic write,
                              input logic [2:0] size, input logic [31:0] wdata);
    gpio_bridge_pkg::ahb_lanes_u wl;
    gpio_bridge_pkg::ahb_lanes_u exp_rd;
    gpio_bridge_pkg::ahb_lanes_u mask;
    logic [1:0] lane;
    int         nbytes;
    int         bank;
    logic       exp_err;
    logic       wait_err;   // error seen while hreadyout low
    logic       done_err;
    wl.word     = wdata;
    nbytes      = 1 << size;
    bank        = int'(addr[7:2]);
    exp_err     = (bank >= N_BANKS);   // no such bank
    exp_rd.word = '0;
    mask.word   = '0;
    for (int i = 0; i < nbytes; i++) begin
      lane               = addr[1:0] + 2'(i);
      mask.bytes[lane]   = 8'hff;
      exp_rd.bytes[lane] = model_byte(addr[7:0] + 8'(i));
    end
    @(posedge HCLK);
    HSEL   <= 1'b1;
    HADDR  <= addr;
    HWRITE <= write;
    HSIZE  <= size;
    HTRANS <= gpio_bridge_pkg::HTRANS_NONSEQ;
    @(posedge HCLK);                   // address phase taken here
    HSEL   <= 1'b0;
    HTRANS <= gpio_bridge_pkg::HTRANS_IDLE;
    HWDATA <= wdata;                   // data phase
    wait_err = 1'b0;
    do begin
      @(negedge HCLK);
      if (!HREADYOUT && HRESP == gpio_bridge_pkg::HRESP_ERROR) wait_err = 1'b1;
    end while (!HREADYOUT);
    done_err = (HRESP == gpio_bridge_pkg::HRESP_ERROR);
    compare("HRESP (wait cycle)", 64'(wait_err), 64'(exp_err));
    compare("HRESP", 64'(done_err), 64'(exp_err));
    if (!write && !exp_err) compare("HRDATA", 64'(HRDATA & mask.word), 64'(exp_rd.word));
    if (write && !exp_err) begin
      for (int i = 0; i < nbytes; i++) begin
        lane = addr[1:0] + 2'(i);
        if (lane == gpio_bridge_pkg::REG_OUT) m_out[bank] = wl.bytes[lane];
        else if (lane == gpio_bridge_pkg::REG_DIR) m_dir[bank] = wl.bytes[lane];
      end
    end
    verify_pins();
  endtask

  initial begin : main
    logic [2:0] sz;
    int         off;
    int         rb;
    void'($urandom(SEED));
    HRESETn <= 1'b0;
    PRESETn <= 1'b0;
    HSEL    <= 1'b0;
    HADDR   <= '0;
    HWRITE  <= 1'b0;
    HSIZE   <= gpio_bridge_pkg::HSIZE_BYTE;
    HPROT   <= 4'b0011;     // privileged data
    HTRANS  <= gpio_bridge_pkg::HTRANS_IDLE;
    HWDATA  <= '0;
    HREADY  <= 1'b1;        // single slave on the bus
    gpio_in <= '0;
    pins_in = '0;
    for (int b = 0; b < N_BANKS; b++) begin
      m_out[b] = 8'h00;
      m_dir[b] = 8'h00;
    end
    repeat (RST_CYCLES / 2) @(posedge HCLK);
    @(negedge HCLK);
    compare("HREADYOUT", 64'(HREADYOUT), 64'(1));
    compare("HRESP", 64'(HRESP), 64'(gpio_bridge_pkg::HRESP_OKAY));
    verify_pins();
    repeat (RST_CYCLES / 2) @(posedge HCLK);
    HRESETn <= 1'b1;
    PRESETn <= 1'b1;
    drive_new_pins();

    // per bank: byte writes and reads, word reads, halfword write, input reg
    for (int b = 0; b < N_BANKS; b++) begin
      bus_transfer(32'(4 * b), 1'b1, gpio_bridge_pkg::HSIZE_BYTE, $urandom());
      bus_transfer(32'(4 * b + 1), 1'b1, gpio_bridge_pkg::HSIZE_BYTE, $urandom());
      bus_transfer(32'(4 * b), 1'b0, gpio_bridge_pkg::HSIZE_BYTE, '0);
      bus_transfer(32'(4 * b + 1), 1'b0, gpio_bridge_pkg::HSIZE_BYTE, '0);
      bus_transfer(32'(4 * b), 1'b0, gpio_bridge_pkg::HSIZE_WORD, '0);
      bus_transfer(32'(4 * b), 1'b1, gpio_bridge_pkg::HSIZE_HWORD, $urandom());
      bus_transfer(32'(4 * b), 1'b0, gpio_bridge_pkg::HSIZE_WORD, '0);
      bus_transfer(32'(4 * b + 2), 1'b1, gpio_bridge_pkg::HSIZE_BYTE, $urandom());
      bus_transfer(32'(4 * b + 2), 1'b0, gpio_bridge_pkg::HSIZE_BYTE, '0);
      bus_transfer(32'(4 * b), 1'b0, gpio_bridge_pkg::HSIZE_WORD, '0);
    end

    // missing bank, error response and nothing changes
    bus_transfer(32'(4 * N_BANKS), 1'b1, gpio_bridge_pkg::HSIZE_WORD, $urandom());
    bus_transfer(32'(4 * N_BANKS + 1), 1'b0, gpio_bridge_pkg::HSIZE_BYTE, '0);
    bus_transfer(32'(0), 1'b0, gpio_bridge_pkg::HSIZE_WORD, '0);

    for (int n = 0; n < N_RANDOM; n++) begin
      if (n % 25 == 0) drive_new_pins();
      sz  = 3'($urandom_range(2, 0));
      off = $urandom_range(3, 0);
      off = (off >> sz) << sz;             // keep it aligned
      rb  = $urandom_range(N_BANKS + 1, 0);  // some banks past the end
      bus_transfer(32'(rb * 4 + off), 1'($urandom_range(1, 0)), sz, $urandom());
    end

    $display("transfers done, checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) $display("Simulation passed");
    else $display("Simulation failed");
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout after %0d ns, transfers did not complete", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: source/gpio_subsystem_top.sv
module gpio_subsystem_top #(
  parameter int SYNC_DEPTH = 3,
  parameter int N_BANKS    = 2,
  parameter int PADDR_SIZE = 8
) (
  input  logic                                   HCLK,
  input  logic                                   HRESETn,
  input  logic                                   PCLK,
  input  logic                                   PRESETn,
  input  logic                                   HSEL,
  input  logic [31:0]                            HADDR,
  input  logic                                   HWRITE,
  input  logic [2:0]                             HSIZE,
  input  logic [3:0]                             HPROT,
  input  logic [1:0]                             HTRANS,
  input  logic [gpio_bridge_pkg::HDATA_SIZE-1:0] HWDATA,
  input  logic                                   HREADY,
  output logic [gpio_bridge_pkg::HDATA_SIZE-1:0] HRDATA,
  output logic                                   HREADYOUT,
  output logic                                   HRESP,
  input  logic [N_BANKS*8-1:0]                   gpio_in,
  output logic [N_BANKS*8-1:0]                   gpio_out,
  output logic [N_BANKS*8-1:0]                   gpio_oe
);

  gpio_bridge_pkg::ahb_req_t req;   // HCLK domain, held until ack
  gpio_bridge_pkg::apb_rsp_t rsp;   // PCLK domain, held until next req

  logic treq;
  logic req_strb;
  logic tack;
  logic tack_strb;

  ////////////////////////////////////////////////////////////////////////////
  // internal apb bus
  ////////////////////////////////////////////////////////////////////////////

  logic                                     psel;
  logic                                     penable;
  logic [PADDR_SIZE-1:0]                    paddr;
  logic                                     pwrite;
  logic [gpio_bridge_pkg::PDATA_SIZE-1:0]   pwdata;
  logic [gpio_bridge_pkg::PDATA_SIZE/8-1:0] pstrb;
  logic [gpio_bridge_pkg::PDATA_SIZE-1:0]   prdata;
  logic                                     pready;
  logic                                     pslverr;

  ahb_slave_port u_ahb (
    .HCLK, .HRESETn, .HSEL, .HADDR, .HWRITE, .HSIZE, .HPROT, .HTRANS,
    .HWDATA, .HREADY, .HRDATA, .HREADYOUT, .HRESP,
    .treq, .req, .tack_strb, .rsp
  );

  // request HCLK to PCLK
  toggle_sync #(.SYNC_DEPTH(SYNC_DEPTH)) u_req_sync (
    .src_clk(HCLK), .src_rst_n(HRESETn), .dst_clk(PCLK), .dst_rst_n(PRESETn),
    .src_strb(treq), .dst_strb(req_strb)
  );

  // acknowledge PCLK to HCLK
  toggle_sync #(.SYNC_DEPTH(SYNC_DEPTH)) u_ack_sync (
    .src_clk(PCLK), .src_rst_n(PRESETn), .dst_clk(HCLK), .dst_rst_n(HRESETn),
    .src_strb(tack), .dst_strb(tack_strb)
  );

  apb_master_port #(.PADDR_SIZE(PADDR_SIZE)) u_apb (
    .PCLK, .PRESETn, .req_strb, .req,
    .PSEL(psel), .PENABLE(penable), .PADDR(paddr), .PWRITE(pwrite),
    .PWDATA(pwdata), .PSTRB(pstrb), .PPROT(),
    .PRDATA(prdata), .PREADY(pready), .PSLVERR(pslverr),
    .tack, .rsp
  );

  apb_gpio #(.N_BANKS(N_BANKS), .PADDR_SIZE(PADDR_SIZE)) u_gpio (
    .PCLK, .PRESETn,
    .PSEL(psel), .PENABLE(penable), .PADDR(paddr), .PWRITE(pwrite),
    .PWDATA(pwdata), .PSTRB(pstrb), .gpio_in,
    .PRDATA(prdata), .PREADY(pready), .PSLVERR(pslverr),
    .gpio_out, .gpio_oe
  );

endmodule

// File: source/apb_gpio.sv
module apb_gpio #(
  parameter int N_BANKS    = 2,
  parameter int PADDR_SIZE = 8
) (
  input  logic                                     PCLK,
  input  logic                                     PRESETn,
  input  logic                                     PSEL,
  input  logic                                     PENABLE,
  input  logic [PADDR_SIZE-1:0]                    PADDR,
  input  logic                                     PWRITE,
  input  logic [gpio_bridge_pkg::PDATA_SIZE-1:0]   PWDATA,
  input  logic [gpio_bridge_pkg::PDATA_SIZE/8-1:0] PSTRB,
  input  logic [N_BANKS*8-1:0]                     gpio_in,
  output logic [gpio_bridge_pkg::PDATA_SIZE-1:0]   PRDATA,
  output logic                                     PREADY,
  output logic                                     PSLVERR,
  output logic [N_BANKS*8-1:0]                     gpio_out,
  output logic [N_BANKS*8-1:0]                     gpio_oe
);

  logic [N_BANKS-1:0][7:0] out_r;     // output value per bank
  logic [N_BANKS-1:0][7:0] dir_r;     // 1 drives the pin
  logic [N_BANKS-1:0][7:0] in_meta;
  logic [N_BANKS-1:0][7:0] in_sync;
  logic [PADDR_SIZE-3:0]   bank;
  logic [1:0]              offs;
  logic                    bank_ok;
  logic                    wr_en;

  assign bank    = PADDR[PADDR_SIZE-1:2];
  assign offs    = PADDR[1:0];
  assign bank_ok = int'(bank) < N_BANKS;
  assign wr_en   = PSEL & PENABLE & PWRITE & PSTRB[0] & bank_ok;   // access cycle

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      out_r <= '0;
      dir_r <= '0;
    end else if (wr_en) begin
      if (offs == gpio_bridge_pkg::REG_OUT) out_r[bank] <= PWDATA;
      if (offs == gpio_bridge_pkg::REG_DIR) dir_r[bank] <= PWDATA;
    end
  end

  // two flop pin synchronizer
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      in_meta <= '0;
      in_sync <= '0;
    end else begin
      in_meta <= gpio_in;
      in_sync <= in_meta;
    end
  end

  always_comb begin
    PRDATA = '0;
    if (bank_ok) begin
      case (offs)
        gpio_bridge_pkg::REG_OUT:  PRDATA = out_r[bank];
        gpio_bridge_pkg::REG_DIR:  PRDATA = dir_r[bank];
        gpio_bridge_pkg::REG_IN:   PRDATA = in_sync[bank];
        gpio_bridge_pkg::REG_RSVD: PRDATA = '0;
      endcase
    end
  end

  assign PREADY   = 1'b1;                        // no wait states
  assign PSLVERR  = PSEL & PENABLE & ~bank_ok;   // missing bank
  assign gpio_out = out_r & dir_r;
  assign gpio_oe  = dir_r;

endmodule

// File: source/apb_master_port.sv
module apb_master_port #(
  parameter int PADDR_SIZE = 8
) (
  input  logic                                     PCLK,
  input  logic                                     PRESETn,
  input  logic                                     req_strb,
  input  gpio_bridge_pkg::ahb_req_t                req,
  output logic                                     PSEL,
  output logic                                     PENABLE,
  output logic [PADDR_SIZE-1:0]                    PADDR,
  output logic                                     PWRITE,
  output logic [gpio_bridge_pkg::PDATA_SIZE-1:0]   PWDATA,
  output logic [gpio_bridge_pkg::PDATA_SIZE/8-1:0] PSTRB,
  output logic [2:0]                               PPROT,
  input  logic [gpio_bridge_pkg::PDATA_SIZE-1:0]   PRDATA,
  input  logic                                     PREADY,
  input  logic                                     PSLVERR,
  output logic                                     tack,
  output gpio_bridge_pkg::apb_rsp_t                rsp
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } state_t;

  state_t     state;
  logic [1:0] beats_left;   // beats after the current one
  logic [1:0] size_beats;
  logic [1:0] lane;         // byte lane of current beat
  logic [1:0] lane_nxt;
  logic       load;
  logic       beat_done;
  logic       finish;

  always_comb begin
    case (req.size)
      gpio_bridge_pkg::HSIZE_BYTE:  size_beats = 2'd0;
      gpio_bridge_pkg::HSIZE_HWORD: size_beats = 2'd1;
      default:                      size_beats = 2'd3;   // word
    endcase
  end

  assign lane      = PADDR[1:0];
  assign lane_nxt  = lane + 2'd1;
  assign load      = (state == ST_IDLE) & req_strb;
  assign beat_done = (state == ST_ACCESS) & PREADY;
  assign finish    = beat_done & (PSLVERR | (beats_left == 2'd0));   // error stops burst

  ////////////////////////////////////////////////////////////////////////////
  // beat sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      state      <= ST_IDLE;
      PSEL       <= 1'b0;
      PENABLE    <= 1'b0;
      PWRITE     <= 1'b0;
      PSTRB      <= '0;
      tack       <= 1'b0;
      beats_left <= 2'd0;
    end else begin
      tack <= 1'b0;
      case (state)
        ST_IDLE: if (load) begin
          state      <= ST_SETUP;
          PSEL       <= 1'b1;
          PWRITE     <= req.write;
          PSTRB      <= {$bits(PSTRB){req.write}};   // strobe only on writes
          beats_left <= size_beats;
        end
        ST_SETUP: begin
          PENABLE <= 1'b1;
          state   <= ST_ACCESS;
        end
        ST_ACCESS: if (beat_done) begin
          PENABLE <= 1'b0;
          if (finish) begin
            PSEL  <= 1'b0;
            tack  <= 1'b1;
            state <= ST_IDLE;
          end else begin
            beats_left <= beats_left - 2'd1;
            state      <= ST_SETUP;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // address, write byte and read assembly
  always_ff @(posedge PCLK) begin
    if (load) begin
      PADDR  <= req.addr[PADDR_SIZE-1:0];
      PWDATA <= req.wdata.bytes[req.addr[1:0]];
      PPROT  <= {~req.prot[0], 1'b0, req.prot[1]};   // instr, nonsecure, priv
      rsp    <= '0;
    end else if (beat_done) begin
      if (!PWRITE) rsp.rdata.bytes[lane] <= PRDATA;   // byte back to its lane
      if (PSLVERR) rsp.slverr <= 1'b1;
      if (!finish) begin
        PADDR  <= PADDR + PADDR_SIZE'(1);
        PWDATA <= req.wdata.bytes[lane_nxt];
      end
    end
  end

endmodule

// File: source/toggle_sync.sv
module toggle_sync #(
  parameter int SYNC_DEPTH = 3
) (
  input  logic src_clk,
  input  logic src_rst_n,
  input  logic dst_clk,
  input  logic dst_rst_n,
  input  logic src_strb,
  output logic dst_strb
);

  logic                  src_tgl;    // flips once per strobe
  logic [SYNC_DEPTH-1:0] dst_sync;   // [0] sees the async edge

  always_ff @(posedge src_clk or negedge src_rst_n) begin
    if (!src_rst_n) src_tgl <= 1'b0;
    else if (src_strb) src_tgl <= ~src_tgl;
  end

  always_ff @(posedge dst_clk or negedge dst_rst_n) begin
    if (!dst_rst_n) dst_sync <= '0;
    else dst_sync <= {dst_sync[SYNC_DEPTH-2:0], src_tgl};
  end

  // any edge of the toggle gives one far clock pulse
  assign dst_strb = dst_sync[SYNC_DEPTH-1] ^ dst_sync[SYNC_DEPTH-2];

endmodule

// File: source/ahb_slave_port.sv
module ahb_slave_port (
  input  logic                                   HCLK,
  input  logic                                   HRESETn,
  input  logic                                   HSEL,
  input  logic [31:0]                            HADDR,
  input  logic                                   HWRITE,
  input  logic [2:0]                             HSIZE,
  input  logic [3:0]                             HPROT,
  input  logic [1:0]                             HTRANS,
  input  logic [gpio_bridge_pkg::HDATA_SIZE-1:0] HWDATA,
  input  logic                                   HREADY,
  output logic [gpio_bridge_pkg::HDATA_SIZE-1:0] HRDATA,
  output logic                                   HREADYOUT,
  output logic                                   HRESP,
  output logic                                   treq,
  output gpio_bridge_pkg::ahb_req_t              req,
  input  logic                                   tack_strb,
  input  gpio_bridge_pkg::apb_rsp_t              rsp
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_XFER,
    ST_ERR
  } state_t;

  state_t state;
  logic   accept;       // valid address phase for us
  logic   data_phase;   // hwdata on the bus this cycle
  logic   ack_q;        // registered acknowledge
  logic   capture;
  logic   done;

  assign accept = HSEL & HREADY &
                  (HTRANS != gpio_bridge_pkg::HTRANS_IDLE) &
                  (HTRANS != gpio_bridge_pkg::HTRANS_BUSY);
  assign capture = (state == ST_IDLE) & accept;
  assign done    = (state == ST_XFER) & ack_q;

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state      <= ST_IDLE;
      HREADYOUT  <= 1'b1;
      HRESP      <= gpio_bridge_pkg::HRESP_OKAY;
      treq       <= 1'b0;
      data_phase <= 1'b0;
      ack_q      <= 1'b0;
    end else begin
      treq  <= 1'b0;        // single cycle strobe
      ack_q <= tack_strb;
      case (state)
        ST_IDLE: begin
          HREADYOUT <= 1'b1;
          HRESP     <= gpio_bridge_pkg::HRESP_OKAY;
          if (accept) begin
            state      <= ST_XFER;
            HREADYOUT  <= 1'b0;   // hold the master
            data_phase <= 1'b1;
          end
        end
        ST_XFER: begin
          if (data_phase) begin
            data_phase <= 1'b0;
            treq       <= 1'b1;   // wdata latched now, send request
          end
          if (ack_q) begin
            if (rsp.slverr) begin
              HRESP <= gpio_bridge_pkg::HRESP_ERROR;  // first error cycle
              state <= ST_ERR;
            end else begin
              HREADYOUT <= 1'b1;
              state     <= ST_IDLE;
            end
          end
        end
        ST_ERR: begin
          HREADYOUT <= 1'b1;      // second error cycle, HRESP stays
          state     <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // request fields and read data
  always_ff @(posedge HCLK) begin
    if (capture) begin
      req.addr  <= HADDR;
      req.write <= HWRITE;
      req.size  <= HSIZE;
      req.prot  <= HPROT[1:0];
    end
    if (data_phase && req.write) req.wdata.word <= HWDATA;   // one cycle after address
    if (done) HRDATA <= rsp.rdata.word;
  end

endmodule

// File: source/gpio_bridge_pkg.sv
package gpio_bridge_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // bus encodings
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  localparam logic [2:0] HSIZE_BYTE  = 3'b000;
  localparam logic [2:0] HSIZE_HWORD = 3'b001;
  localparam logic [2:0] HSIZE_WORD  = 3'b010;

  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

  localparam int HDATA_SIZE = 32;   // ahb data bus
  localparam int PDATA_SIZE = 8;    // apb data bus, one byte per beat

  // gpio register offsets inside a 4 byte bank window
  localparam logic [1:0] REG_OUT  = 2'd0;
  localparam logic [1:0] REG_DIR  = 2'd1;
  localparam logic [1:0] REG_IN   = 2'd2;
  localparam logic [1:0] REG_RSVD = 2'd3;

  ////////////////////////////////////////////////////////////////////////////
  // crossing payloads
  ////////////////////////////////////////////////////////////////////////////

  // one ahb data word, seen whole or per byte lane
  typedef union packed {
    logic [HDATA_SIZE-1:0]                            word;
    logic [HDATA_SIZE/PDATA_SIZE-1:0][PDATA_SIZE-1:0] bytes;
  } ahb_lanes_u;

  typedef struct packed {
    logic [31:0] addr;
    logic        write;
    logic [2:0]  size;
    logic [1:0]  prot;    // [1] privileged, [0] data
    ahb_lanes_u  wdata;
  } ahb_req_t;

  typedef struct packed {
    ahb_lanes_u rdata;
    logic       slverr;
  } apb_rsp_t;

endpackage
